//--- rtl/hdcpu_pkg.sv
`default_nettype none

package hdcpu_pkg;

    // Front panel mode switches
    localparam logic [2:0] SW_EXEC = 3'b000;
    localparam logic [2:0] SW_WMEM = 3'b001;
    localparam logic [2:0] SW_RMEM = 3'b010;
    localparam logic [2:0] SW_RREG = 3'b011;
    localparam logic [2:0] SW_WREG = 3'b100;

    // Opcode nibble ir[7:4]
    localparam logic [3:0] OP_ADD = 4'b0001;
    localparam logic [3:0] OP_SUB = 4'b0010;
    localparam logic [3:0] OP_AND = 4'b0011;
    localparam logic [3:0] OP_INC = 4'b0100;
    localparam logic [3:0] OP_LD  = 4'b0101;
    localparam logic [3:0] OP_ST  = 4'b0110;
    localparam logic [3:0] OP_JC  = 4'b0111;
    localparam logic [3:0] OP_JZ  = 4'b1000;
    localparam logic [3:0] OP_OUT = 4'b1010;
    localparam logic [3:0] OP_OR  = 4'b1100;
    localparam logic [3:0] OP_XOR = 4'b1101;
    localparam logic [3:0] OP_STP = 4'b1110;

    // 74181 style function select
    localparam logic [3:0] ALU_ADD    = 4'b1001;
    localparam logic [3:0] ALU_SUB    = 4'b0110;
    localparam logic [3:0] ALU_AND    = 4'b1011;
    localparam logic [3:0] ALU_OR     = 4'b1110;
    localparam logic [3:0] ALU_XOR    = 4'b0110; // Logic mode, m high
    localparam logic [3:0] ALU_INC    = 4'b0000;
    localparam logic [3:0] ALU_PASS_A = 4'b1010;
    localparam logic [3:0] ALU_PASS_B = 4'b1111;

    typedef struct packed {
        logic [1:0] rd; // Destination register
        logic [1:0] rs; // Source register
    } sel_fields_t;

    // Register select word, driven as raw bits or as rd/rs fields
    typedef union packed {
        logic [3:0]  raw;
        sel_fields_t f;
    } sel_t;

endpackage

`default_nettype wire

//--- rtl/hdcpu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module hdcpu_exec (
    input  wire logic [3:1]     w,
    input  wire logic [7:4]     ir,
    input  wire logic           c,
    input  wire logic           z,
    input  wire logic           st0,
    output logic                x_ldc,
    output logic                x_ldz,
    output logic                x_cin,
    output logic                x_m,
    output logic                x_abus,
    output logic                x_drw,
    output logic                x_pcinc,
    output logic                x_lpc,
    output logic                x_lar,
    output logic                x_pcadd,
    output logic                x_selctl,
    output logic                x_memw,
    output logic                x_stop,
    output logic                x_lir,
    output logic                x_sbus,
    output logic                x_mbus,
    output logic                x_short_cyc,
    output logic                x_long_cyc,
    output logic [3:0]          x_s,
    output hdcpu_pkg::sel_t     x_sel,
    output logic                x_sst0
);

    import hdcpu_pkg::*;

    logic exe_beat;

    assign exe_beat = w[2] | w[3]; // Beats that carry the opcode

    always_comb begin
        x_ldc       = 1'b0;
        x_ldz       = 1'b0;
        x_cin       = 1'b0;
        x_m         = 1'b0;
        x_abus      = 1'b0;
        x_drw       = 1'b0;
        x_pcinc     = 1'b0;
        x_lpc       = 1'b0;
        x_lar       = 1'b0;
        x_pcadd     = 1'b0;
        x_selctl    = 1'b0; // Register file addressed by ir
        x_memw      = 1'b0;
        x_stop      = 1'b0;
        x_lir       = 1'b0;
        x_sbus      = 1'b0;
        x_mbus      = 1'b0;
        x_short_cyc = 1'b0;
        x_long_cyc  = 1'b0;
        x_s         = 4'b0000;
        x_sel       = '0;
        x_sst0      = 1'b0;

        if (!st0) begin
            // Start address comes in from the switches
            x_lpc       = w[1];
            x_sbus      = w[1];
            x_short_cyc = w[1];
            x_stop      = w[1];
            x_sst0      = w[1];
        end else begin
            x_lir   = w[1]; // Fetch
            x_pcinc = w[1];
            if (exe_beat) begin
                case (ir)
                    OP_ADD, OP_SUB: begin
                        x_s    = (ir == OP_ADD) ? ALU_ADD : ALU_SUB;
                        x_cin  = w[2] && (ir == OP_ADD);
                        x_abus = w[2];
                        x_drw  = w[2];
                        x_ldz  = w[2];
                        x_ldc  = w[2];
                    end
                    OP_AND, OP_OR, OP_XOR: begin
                        x_m = w[2];
                        case (ir)
                            OP_AND:  x_s = ALU_AND;
                            OP_OR:   x_s = ALU_OR;
                            default: x_s = ALU_XOR;
                        endcase
                        x_abus = w[2];
                        x_drw  = w[2];
                        x_ldz  = w[2]; // Carry untouched by logic ops
                    end
                    OP_INC: begin
                        x_s    = ALU_INC;
                        x_abus = w[2];
                        x_drw  = w[2];
                        x_ldz  = w[2];
                        x_ldc  = w[2];
                    end
                    OP_LD: begin
                        x_m        = w[2];
                        x_s        = ALU_PASS_A;
                        x_abus     = w[2];
                        x_lar      = w[2]; // Address from rs
                        x_long_cyc = w[2];
                        x_drw      = w[3];
                        x_mbus     = w[3];
                    end
                    OP_ST: begin
                        x_m        = exe_beat;
                        x_s        = w[2] ? ALU_PASS_B : ALU_PASS_A;
                        x_abus     = exe_beat;
                        x_lar      = w[2];
                        x_long_cyc = w[2];
                        x_memw     = w[3];
                    end
                    OP_JC:  x_pcadd = w[2] && c;
                    OP_JZ:  x_pcadd = w[2] && z;
                    OP_OUT: begin
                        x_m    = w[2];
                        x_s    = ALU_PASS_A;
                        x_abus = w[2];
                    end
                    OP_STP: x_stop = w[2];
                    default: x_s = 4'b0000;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/hdcpu_console.sv
`timescale 1ns/1ps
`default_nettype none

module hdcpu_console (
    input  wire logic           t3,
    input  wire logic           rst_n,
    input  wire logic [2:0]     sw,
    input  wire logic [3:1]     w,
    input  wire logic           x_ldc,
    input  wire logic           x_ldz,
    input  wire logic           x_cin,
    input  wire logic           x_m,
    input  wire logic           x_abus,
    input  wire logic           x_drw,
    input  wire logic           x_pcinc,
    input  wire logic           x_lpc,
    input  wire logic           x_lar,
    input  wire logic           x_pcadd,
    input  wire logic           x_selctl,
    input  wire logic           x_memw,
    input  wire logic           x_stop,
    input  wire logic           x_lir,
    input  wire logic           x_sbus,
    input  wire logic           x_mbus,
    input  wire logic           x_short_cyc,
    input  wire logic           x_long_cyc,
    input  wire logic [3:0]     x_s,
    input  wire hdcpu_pkg::sel_t x_sel,
    input  wire logic           x_sst0,
    output logic                st0,
    output logic                ldc,
    output logic                ldz,
    output logic                cin,
    output logic                m,
    output logic                abus,
    output logic                drw,
    output logic                pcinc,
    output logic                lpc,
    output logic                lar,
    output logic                pcadd,
    output logic                arinc,
    output logic                selctl,
    output logic                memw,
    output logic                stop,
    output logic                lir,
    output logic                sbus,
    output logic                mbus,
    output logic                short_cyc,
    output logic                long_cyc,
    output logic [3:0]          s,
    output hdcpu_pkg::sel_t     sel
);

    import hdcpu_pkg::*;

    logic sst0;
    logic clr_st0;
    logic reg_beat;

    assign reg_beat = w[1] | w[2];
    assign clr_st0  = (sw == SW_WREG) && st0 && w[2]; // Second pair written

    always_ff @(posedge t3 or negedge rst_n) begin
        if (!rst_n) begin
            st0 <= 1'b0;
        end else if (sst0) begin
            st0 <= 1'b1; // Set wins
        end else if (clr_st0) begin
            st0 <= 1'b0;
        end
    end

    always_comb begin
        {ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd} = '0;
        {arinc, selctl, memw, stop, lir, sbus, mbus, short_cyc, long_cyc} = '0;
        s    = 4'b0000;
        sel  = '0;
        sst0 = 1'b0;

        case (sw)
            SW_EXEC: begin
                {ldc, ldz, cin, m, abus} = {x_ldc, x_ldz, x_cin, x_m, x_abus};
                {drw, pcinc, lpc, lar, pcadd} = {x_drw, x_pcinc, x_lpc, x_lar, x_pcadd};
                {selctl, memw, stop, lir} = {x_selctl, x_memw, x_stop, x_lir};
                {sbus, mbus, short_cyc, long_cyc} = {x_sbus, x_mbus, x_short_cyc, x_long_cyc};
                s    = x_s;
                sel  = x_sel;
                sst0 = x_sst0;
            end
            SW_WMEM: begin
                lar       = w[1] && !st0; // Address first
                memw      = w[1] && st0;
                arinc     = w[1] && st0;
                sbus      = w[1];
                stop      = w[1];
                short_cyc = w[1];
                selctl    = w[1];
                sst0      = w[1];
            end
            SW_RMEM: begin
                sbus      = w[1] && !st0;
                lar       = w[1] && !st0;
                sst0      = w[1] && !st0;
                mbus      = w[1] && st0;
                arinc     = w[1] && st0;
                stop      = w[1];
                short_cyc = w[1];
                selctl    = w[1];
            end
            SW_RREG: begin
                selctl   = reg_beat;
                stop     = reg_beat;
                sel.f.rd = {w[2], 1'b0}; // R0/R1 then R2/R3
                sel.f.rs = {w[2], reg_beat};
            end
            SW_WREG: begin
                sbus   = reg_beat;
                selctl = reg_beat;
                drw    = reg_beat;
                stop   = reg_beat;
                sst0   = !st0 && w[2];
                sel.raw[3] = st0 && reg_beat;
                sel.raw[2] = w[2];
                sel.raw[1] = (!st0 && w[1]) || (st0 && w[2]);
                sel.raw[0] = w[1];
            end
            default: begin
                sst0 = 1'b0; // Undefined switch codes stay idle
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/hdcpu.sv
`timescale 1ns/1ps
`default_nettype none

module hdcpu (
    input  wire logic           t3,
    input  wire logic           rst_n,
    input  wire logic [2:0]     sw,
    input  wire logic [3:1]     w,
    input  wire logic [7:4]     ir,
    input  wire logic           c,
    input  wire logic           z,
    output logic                ldc,
    output logic                ldz,
    output logic                cin,
    output logic                m,
    output logic                abus,
    output logic                drw,
    output logic                pcinc,
    output logic                lpc,
    output logic                lar,
    output logic                pcadd,
    output logic                arinc,
    output logic                selctl,
    output logic                memw,
    output logic                stop,
    output logic                lir,
    output logic                sbus,
    output logic                mbus,
    output logic                short_cyc,
    output logic                long_cyc,
    output logic [3:0]          s,
    output hdcpu_pkg::sel_t     sel
);

    import hdcpu_pkg::*;

    logic st0;

    // Candidate strobes from the instruction decoder
    logic x_ldc, x_ldz, x_cin, x_m, x_abus, x_drw;
    logic x_pcinc, x_lpc, x_lar, x_pcadd, x_selctl, x_memw;
    logic x_stop, x_lir, x_sbus, x_mbus, x_short_cyc, x_long_cyc;
    logic [3:0] x_s;
    sel_t x_sel;
    logic x_sst0;

    hdcpu_exec i_exec (
        .*
    );

    hdcpu_console i_console (
        .*
    );

endmodule

`default_nettype wire

//--- dv/hdcpu_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module hdcpu_clk_gen #(
    parameter int CLK_PERIOD   = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic t3,
    output logic rst_n
);

    initial begin
        t3    = 1'b0;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge t3);
        @(negedge t3);
        rst_n = 1'b1; // Release away from the rising edge
    end

    always #(CLK_PERIOD / 2) t3 = ~t3;

endmodule

`default_nettype wire

//--- dv/hdcpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hdcpu_tb;

    import hdcpu_pkg::*;

    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 3;
    localparam int NUM_CYCLES     = 4000;
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 4;
    localparam int CHECK_DELAY    = CLK_PERIOD / 2 - 1; // Just before the rising edge
    localparam logic [31:0] SEED  = 32'h72888566;

    typedef struct packed {
        logic ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd;
        logic arinc, selctl, memw, stop, lir, sbus, mbus, short_cyc, long_cyc;
        logic [3:0] s;
        logic [3:0] sel;
        logic sst0;
    } ctrl_t;

    logic t3;
    logic rst_n;
    logic [2:0] sw;
    logic [3:1] w;
    logic [7:4] ir;
    logic c;
    logic z;
    logic ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd;
    logic arinc, selctl, memw, stop, lir, sbus, mbus, short_cyc, long_cyc;
    logic [3:0] s;
    sel_t sel;

    logic model_st0;
    ctrl_t edge_exp;
    int error_count;
    int check_count;
    int cycle_count;

    hdcpu_clk_gen #(.CLK_PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clk_gen (
        .t3(t3),
        .rst_n(rst_n)
    );

    hdcpu i_hdcpu (.*);

    // Expected strobes for one set of panel inputs and the current phase
    function automatic ctrl_t model_outputs(input logic [2:0] mode, input logic [3:1] beat,
                                            input logic [7:4] op, input logic cf,
                                            input logic zf, input logic phase);
        ctrl_t o;
        logic pair_beat;
        o         = '0;
        pair_beat = beat[1] | beat[2];
        case (mode)
            SW_EXEC: begin
                if (!phase) begin
                    {o.lpc, o.sbus, o.short_cyc, o.stop, o.sst0} = {5{beat[1]}}; // PC load
                end else begin
                    {o.lir, o.pcinc} = {2{beat[1]}};
                    if (beat[2] | beat[3]) begin
                        case (op)
                            OP_ADD: {o.s, o.cin, o.abus, o.drw, o.ldz, o.ldc} =
                                        {ALU_ADD, {5{beat[2]}}};
                            OP_SUB: {o.s, o.abus, o.drw, o.ldz, o.ldc} = {ALU_SUB, {4{beat[2]}}};
                            OP_INC: {o.s, o.abus, o.drw, o.ldz, o.ldc} = {ALU_INC, {4{beat[2]}}};
                            OP_AND: {o.s, o.m, o.abus, o.drw, o.ldz} = {ALU_AND, {4{beat[2]}}};
                            OP_OR:  {o.s, o.m, o.abus, o.drw, o.ldz} = {ALU_OR, {4{beat[2]}}};
                            OP_XOR: {o.s, o.m, o.abus, o.drw, o.ldz} = {ALU_XOR, {4{beat[2]}}};
                            OP_LD: begin
                                {o.s, o.m, o.abus} = {ALU_PASS_A, {2{beat[2]}}};
                                {o.lar, o.long_cyc, o.drw, o.mbus} = {{2{beat[2]}}, {2{beat[3]}}};
                            end
                            OP_ST: begin
                                o.s = beat[2] ? ALU_PASS_B : ALU_PASS_A; // Address, then data
                                {o.m, o.abus, o.lar, o.long_cyc} = {2'b11, {2{beat[2]}}};
                                o.memw = beat[3];
                            end
                            OP_JC:  o.pcadd = beat[2] && cf;
                            OP_JZ:  o.pcadd = beat[2] && zf;
                            OP_OUT: {o.s, o.m, o.abus} = {ALU_PASS_A, {2{beat[2]}}};
                            OP_STP: o.stop = beat[2];
                            default: o.s = 4'h0;
                        endcase
                    end
                end
            end
            SW_WMEM: begin
                {o.sbus, o.stop, o.short_cyc, o.selctl, o.sst0} = {5{beat[1]}};
                {o.lar, o.memw, o.arinc} = {beat[1] && !phase, {2{beat[1] && phase}}};
            end
            SW_RMEM: begin
                {o.stop, o.short_cyc, o.selctl} = {3{beat[1]}};
                {o.sbus, o.lar, o.sst0} = {3{beat[1] && !phase}};
                {o.mbus, o.arinc} = {2{beat[1] && phase}};
            end
            SW_RREG: begin
                {o.selctl, o.stop} = {2{pair_beat}};
                o.sel = beat[2] ? 4'b1011 : {3'b000, beat[1]}; // R0/R1 then R2/R3
            end
            SW_WREG: begin
                {o.sbus, o.selctl, o.drw, o.stop} = {4{pair_beat}};
                o.sst0 = !phase && beat[2];
                if (pair_beat) begin
                    o.sel = phase ? (beat[2] ? 4'b1110 : 4'b1001) : (beat[2] ? 4'b0100 : 4'b0011);
                end
            end
            default: o = '0;
        endcase
        return o;
    endfunction

    task automatic compare_field(input string name, input logic [3:0] expected,
                                 input logic [3:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("mismatch %s: expected %h, got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_outputs();
        ctrl_t e;
        e = model_outputs(sw, w, ir, c, z, model_st0);
        compare_field("ldc", e.ldc, ldc);
        compare_field("ldz", e.ldz, ldz);
        compare_field("cin", e.cin, cin);
        compare_field("m", e.m, m);
        compare_field("abus", e.abus, abus);
        compare_field("drw", e.drw, drw);
        compare_field("pcinc", e.pcinc, pcinc);
        compare_field("lpc", e.lpc, lpc);
        compare_field("lar", e.lar, lar);
        compare_field("pcadd", e.pcadd, pcadd);
        compare_field("arinc", e.arinc, arinc);
        compare_field("selctl", e.selctl, selctl);
        compare_field("memw", e.memw, memw);
        compare_field("stop", e.stop, stop);
        compare_field("lir", e.lir, lir);
        compare_field("sbus", e.sbus, sbus);
        compare_field("mbus", e.mbus, mbus);
        compare_field("short_cyc", e.short_cyc, short_cyc);
        compare_field("long_cyc", e.long_cyc, long_cyc);
        compare_field("s", e.s, s);
        compare_field("sel", e.sel, sel);
    endtask

    task automatic drive_random();
        int unsigned beat;
        beat = $urandom % 4;
        sw   = ($urandom % 2) ? $urandom % 5 : SW_EXEC; // Codes 0 to 4 are the defined modes
        w    = (beat == 0) ? 3'b000 : 3'b001 << (beat - 1);
        ir   = $urandom % 16;
        c    = $urandom % 2;
        z    = $urandom % 2;
    endtask

    always @(posedge t3 or negedge rst_n) begin
        if (!rst_n) begin
            model_st0 <= 1'b0;
        end else begin
            edge_exp = model_outputs(sw, w, ir, c, z, model_st0);
            if (edge_exp.sst0) begin
                model_st0 <= 1'b1;
            end else if (sw == SW_WREG && model_st0 && w[2]) begin
                model_st0 <= 1'b0; // Both register pairs written
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        sw          = SW_EXEC;
        w           = 3'b000;
        ir          = 4'h0;
        c           = 1'b0;
        z           = 1'b0;
        error_count = 0;
        check_count = 0;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(negedge t3);
            if (i == RESET_CYCLES - 1) begin
                w = 3'b001; // First beat out of reset loads the PC
            end else if (i >= RESET_CYCLES) begin
                drive_random();
            end
            #CHECK_DELAY;
            check_outputs();
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge t3);
            cycle_count++;
        end
        $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
rtl/hdcpu_pkg.sv
rtl/hdcpu_exec.sv
rtl/hdcpu_console.sv
rtl/hdcpu.sv
dv/hdcpu_clk_gen.sv
dv/hdcpu_tb.sv
